// ==== flist.f ====
seq_ctrl_pkg.sv
cond_eval.sv
transition_logic.sv
action_decoder.sv
seq_ctrl_top.sv
tb_seq_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_seq_ctrl -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log || ! grep -q "RESULT: PASS" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

// ==== tb_seq_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_seq_ctrl;

	localparam int reps = 40;
	localparam int test_cycles = 3 + 20 + 50 + reps * 3 + reps * 5 + reps * 5;
	localparam int timeout_cycles = test_cycles + 100;

	// The DUT clock port is rst and its active-low reset port is clk
	logic rst = 1'b0;
	logic clk = 1'b0;
	seq_ctrl_pkg::cond_vec_t x = '0;
	seq_ctrl_pkg::ctrl_word_t y;

	int errors = 0;
	int test_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	seq_ctrl_top dut_i (
		.rst(rst),
		.clk(clk),
		.x(x),
		.y(y)
	);

	always #5 rst = ~rst;

	initial
	begin
		#(timeout_cycles * 10);
		$display("Watchdog expired before the tests completed");
		$display("RESULT: FAIL");
		$finish;
	end

	// Word with only output yk raised
	function automatic seq_ctrl_pkg::ctrl_word_t out_bit(input int k);
		seq_ctrl_pkg::ctrl_word_t w;
		w = '0;
		w[k-1] = 1'b1;
		return w;
	endfunction

	// Idle hold pattern selected by x20 and x19
	function automatic seq_ctrl_pkg::ctrl_word_t idle_expect(input seq_ctrl_pkg::cond_vec_t xv);
		if (xv[19] && xv[18])
			return out_bit(17) | out_bit(29) | out_bit(34);
		else if (xv[19])
			return out_bit(34);
		else if (xv[18])
			return out_bit(39);
		return out_bit(36);
	endfunction

	function automatic logic exit_rule(input seq_ctrl_pkg::cond_vec_t xv);
		return xv[16] && (xv[9] || xv[10]);
	endfunction

	function automatic logic ready_rule(input seq_ctrl_pkg::cond_vec_t xv);
		if (xv[14] && xv[15])
			return 1'b1;
		if (xv[14])
			return xv[8];
		if (xv[15])
			return xv[7];
		return xv[6];
	endfunction

	function automatic seq_ctrl_pkg::cond_vec_t random_x();
		return seq_ctrl_pkg::cond_vec_t'($urandom);
	endfunction

	// Drives one cycle at the rising edge and checks y in the middle of it
	task automatic apply_cycle(input seq_ctrl_pkg::cond_vec_t xv,
		input seq_ctrl_pkg::ctrl_word_t exp, input logic rst_n);
		@(posedge rst);
		x <= xv;
		clk <= rst_n;
		@(negedge rst);
		assert (y === exp)
		else
		begin
			$display("Error at %0t ns: signal y expected %h, got %h", $time, exp, y);
			test_errors++;
		end
	endtask

	task automatic idle_cycle();
		seq_ctrl_pkg::cond_vec_t xv;
		xv = random_x();
		xv[5] = 1'b1;
		xv[4] = 1'b1;
		apply_cycle(xv, idle_expect(xv), 1'b1);
	endtask

	// Leaves idle on the long path and ends in s4
	task automatic enter_long_path();
		seq_ctrl_pkg::cond_vec_t xv;
		xv = random_x();
		xv[5] = 1'b1;
		xv[4] = 1'b0;
		xv[3] = 1'b0;
		apply_cycle(xv, out_bit(35) | out_bit(37), 1'b1);
		apply_cycle(random_x(), out_bit(20), 1'b1);
	endtask

	task automatic report_test(input string name);
		tests_run++;
		errors += test_errors;
		if (test_errors == 0)
			$display("Test %s: passed", name);
		else
		begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	initial
	begin
		seq_ctrl_pkg::cond_vec_t xv;
		int ready_hits;
		int exit_hits;
		void'($urandom(49905));
		ready_hits = 0;
		exit_hits = 0;

		// Reset is held through the first three edges
		for (int i = 0; i < 23; i++)
		begin
			xv = random_x();
			xv[5] = 1'b0;
			apply_cycle(xv, '0, i >= 3);
		end
		report_test("reset_idle");

		repeat (50)
			idle_cycle();
		report_test("idle_hold");

		repeat (reps)
		begin
			xv = random_x();
			xv[5] = 1'b1;
			xv[4] = 1'b0;
			xv[3] = 1'b1;
			apply_cycle(xv, out_bit(1) | out_bit(17) | out_bit(19) | out_bit(29) | out_bit(36),
				1'b1);
			apply_cycle(random_x(),
				out_bit(1) | out_bit(18) | out_bit(25) | out_bit(35) | out_bit(38), 1'b1);
			idle_cycle();
		end
		report_test("short_excursion");

		repeat (reps)
		begin
			enter_long_path();
			xv = random_x();
			xv[11] = 1'b1;
			xv[13] = 1'b1;
			xv[12] = 1'b1;
			apply_cycle(xv, xv[15] ? out_bit(25) : out_bit(24), 1'b1);
			xv = random_x();
			apply_cycle(xv, exit_rule(xv) ? out_bit(28) : seq_ctrl_pkg::ctrl_word_t'(0), 1'b1);
			idle_cycle();
		end
		report_test("long_path_exit");

		repeat (reps)
		begin
			enter_long_path();
			xv = random_x();
			xv[11] = 1'b0;
			xv[2] = 1'b0;
			xv[13] = 1'b0;
			xv[12] = 1'b1;
			if (ready_rule(xv))
			begin
				ready_hits++;
				apply_cycle(xv, out_bit(7) | out_bit(8), 1'b1);
				// Abort back to idle through the reset
				xv = random_x();
				xv[5] = 1'b0;
				apply_cycle(xv, '0, 1'b0);
				idle_cycle();
			end
			else
			begin
				exit_hits++;
				apply_cycle(xv, exit_rule(xv) ? out_bit(28) : seq_ctrl_pkg::ctrl_word_t'(0),
					1'b1);
				idle_cycle();
			end
		end
		$display("Ready branch taken %0d times, exit branch %0d times", ready_hits, exit_hits);
		report_test("ready_select");

		@(posedge rst);
		$display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== seq_ctrl_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module seq_ctrl_top (
	input wire rst,
	input wire clk,
	input wire seq_ctrl_pkg::cond_vec_t x,
	output seq_ctrl_pkg::ctrl_word_t y
);

	logic exit_ok;
	logic ready_ok;
	seq_ctrl_pkg::action_t action;

	cond_eval cond_eval_i (
		.x(x),
		.exit_ok(exit_ok),
		.ready_ok(ready_ok)
	);

	// rst is the clock and clk the active-low reset
	transition_logic transition_logic_i (
		.rst(rst),
		.clk(clk),
		.x(x),
		.exit_ok(exit_ok),
		.ready_ok(ready_ok),
		.action(action)
	);

	action_decoder action_decoder_i (
		.action(action),
		.y(y)
	);

endmodule

`default_nettype wire

// ==== action_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module action_decoder (
	input wire seq_ctrl_pkg::action_t action,
	output seq_ctrl_pkg::ctrl_word_t y
);

	// Word with only output yk raised
	function automatic seq_ctrl_pkg::ctrl_word_t y_bit(input int k);
		return seq_ctrl_pkg::ctrl_word_t'(1) << (k - 1);
	endfunction

	always_comb
	begin
		case (action)
			seq_ctrl_pkg::act_idle_full:
				y = y_bit(17) | y_bit(29) | y_bit(34);
			seq_ctrl_pkg::act_idle_hold:
				y = y_bit(34);
			seq_ctrl_pkg::act_idle_alt:
				y = y_bit(39);
			seq_ctrl_pkg::act_idle_wait:
				y = y_bit(36);
			seq_ctrl_pkg::act_start_short:
				y = y_bit(1) | y_bit(17) | y_bit(19) | y_bit(29) | y_bit(36);
			seq_ctrl_pkg::act_start_long:
				y = y_bit(35) | y_bit(37);
			seq_ctrl_pkg::act_short_done:
				y = y_bit(1) | y_bit(18) | y_bit(25) | y_bit(35) | y_bit(38);
			seq_ctrl_pkg::act_fetch:
				y = y_bit(20);
			seq_ctrl_pkg::act_dir_pos:
				y = y_bit(25);
			seq_ctrl_pkg::act_dir_neg:
				y = y_bit(24);
			seq_ctrl_pkg::act_load:
				y = y_bit(8);
			seq_ctrl_pkg::act_mem_write:
				y = y_bit(2) | y_bit(5) | y_bit(6) | y_bit(8) | y_bit(11) | y_bit(12)
					| y_bit(21);
			seq_ctrl_pkg::act_exit:
				y = y_bit(28);
			seq_ctrl_pkg::act_branch:
				y = y_bit(9) | y_bit(35) | y_bit(36);
			seq_ctrl_pkg::act_load_ready:
				y = y_bit(7) | y_bit(8);
			seq_ctrl_pkg::act_step:
				y = y_bit(5);
			seq_ctrl_pkg::act_commit:
				y = y_bit(3) | y_bit(26);
			seq_ctrl_pkg::act_latch:
				y = y_bit(27);
			seq_ctrl_pkg::act_call:
				y = y_bit(1) | y_bit(33) | y_bit(34);
			seq_ctrl_pkg::act_mem_access:
				y = y_bit(3) | y_bit(5) | y_bit(6) | y_bit(8) | y_bit(10) | y_bit(11);
			// y1 through y6 together
			seq_ctrl_pkg::act_wide_op:
				y = y_bit(1) | y_bit(2) | y_bit(3) | y_bit(4) | y_bit(5) | y_bit(6);
			seq_ctrl_pkg::act_return:
				y = y_bit(1) | y_bit(18);
			seq_ctrl_pkg::act_block:
				y = y_bit(13) | y_bit(14) | y_bit(15) | y_bit(16);
			seq_ctrl_pkg::act_strobe:
				y = y_bit(6);
			seq_ctrl_pkg::act_finish:
				y = y_bit(10) | y_bit(26);
			seq_ctrl_pkg::act_mark:
				y = y_bit(9) | y_bit(29);
			seq_ctrl_pkg::act_restart:
				y = y_bit(18) | y_bit(19);
			seq_ctrl_pkg::act_probe:
				y = y_bit(9);
			seq_ctrl_pkg::act_mem_read:
				y = y_bit(2) | y_bit(5) | y_bit(6) | y_bit(8) | y_bit(10) | y_bit(11)
					| y_bit(12);
			seq_ctrl_pkg::act_pair:
				y = y_bit(22) | y_bit(23);
			seq_ctrl_pkg::act_resume:
				y = y_bit(1) | y_bit(17);
			seq_ctrl_pkg::act_flush:
				y = y_bit(30) | y_bit(31) | y_bit(32) | y_bit(33);
			default:
				y = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== transition_logic.sv ====
`timescale 1ns/10ps
`default_nettype none

module transition_logic (
	input wire rst,
	input wire clk,
	input wire seq_ctrl_pkg::cond_vec_t x,
	input wire exit_ok,
	input wire ready_ok,
	output seq_ctrl_pkg::action_t action
);

	localparam int state_bits = $bits(seq_ctrl_pkg::ctrl_state_t);
	localparam int action_bits = $bits(seq_ctrl_pkg::action_t);

	seq_ctrl_pkg::ctrl_state_t state_q;
	seq_ctrl_pkg::ctrl_state_t state_d;

	// Next state in the upper field, action code in the lower field
	logic [state_bits+action_bits-1:0] step;
	logic [state_bits+action_bits-1:0] exit_step;

	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
			state_q <= seq_ctrl_pkg::st_idle;
		else
			state_q <= state_d;
	end

	// Shared return to idle, raising y28 only when the exit test holds
	assign exit_step = {seq_ctrl_pkg::st_idle,
		exit_ok ? seq_ctrl_pkg::act_exit : seq_ctrl_pkg::act_none};

	always_comb
	begin
		step = {state_q, seq_ctrl_pkg::act_none};
		case (state_q)
			seq_ctrl_pkg::st_idle:
			begin
				if (x[5] && x[4])
				begin
					case ({x[19], x[18]})
						2'b11:
							step = {seq_ctrl_pkg::st_idle, seq_ctrl_pkg::act_idle_full};
						2'b10:
							step = {seq_ctrl_pkg::st_idle, seq_ctrl_pkg::act_idle_hold};
						2'b01:
							step = {seq_ctrl_pkg::st_idle, seq_ctrl_pkg::act_idle_alt};
						default:
							step = {seq_ctrl_pkg::st_idle, seq_ctrl_pkg::act_idle_wait};
					endcase
				end
				else if (x[5])
					step = x[3] ? {seq_ctrl_pkg::st_s2, seq_ctrl_pkg::act_start_short}
						: {seq_ctrl_pkg::st_s3, seq_ctrl_pkg::act_start_long};
			end
			seq_ctrl_pkg::st_s2:
				step = {seq_ctrl_pkg::st_idle, seq_ctrl_pkg::act_short_done};
			seq_ctrl_pkg::st_s3:
				step = {seq_ctrl_pkg::st_s4, seq_ctrl_pkg::act_fetch};
			seq_ctrl_pkg::st_s4:
			begin
				if (x[11] && x[13])
					step = x[12] ? {seq_ctrl_pkg::st_s5,
						x[15] ? seq_ctrl_pkg::act_dir_pos : seq_ctrl_pkg::act_dir_neg}
						: {seq_ctrl_pkg::st_s6, seq_ctrl_pkg::act_load};
				else if (x[11] && x[14])
					step = (x[12] && !x[15]) ? {seq_ctrl_pkg::st_s7, seq_ctrl_pkg::act_mem_write}
						: {seq_ctrl_pkg::st_s6, seq_ctrl_pkg::act_load};
				else if (x[11] && x[12])
					step = (x[15] ? x[10] : x[9])
						? {seq_ctrl_pkg::st_s8, seq_ctrl_pkg::act_fetch} : exit_step;
				else if (x[2])
					step = {seq_ctrl_pkg::st_s9, seq_ctrl_pkg::act_branch};
				else if (x[11])
					step = (x[15] && !x[0]) ? {seq_ctrl_pkg::st_s6, seq_ctrl_pkg::act_load}
						: {seq_ctrl_pkg::st_s10, seq_ctrl_pkg::act_load_ready};
				else if (x[12] && !ready_ok)
					step = exit_step;
				else
					step = {seq_ctrl_pkg::st_s10, seq_ctrl_pkg::act_load_ready};
			end
			seq_ctrl_pkg::st_s5:
				step = exit_step;
			seq_ctrl_pkg::st_s6:
				step = {x[12] ? seq_ctrl_pkg::st_s11 : seq_ctrl_pkg::st_s12,
					seq_ctrl_pkg::act_step};
			seq_ctrl_pkg::st_s7:
				step = {seq_ctrl_pkg::st_s13, seq_ctrl_pkg::act_commit};
			seq_ctrl_pkg::st_s8:
				step = {seq_ctrl_pkg::st_s5, seq_ctrl_pkg::act_fetch};
			seq_ctrl_pkg::st_s9:
				step = {seq_ctrl_pkg::st_s14, seq_ctrl_pkg::act_fetch};
			seq_ctrl_pkg::st_s10:
				step = {seq_ctrl_pkg::st_s15, seq_ctrl_pkg::act_step};
			seq_ctrl_pkg::st_s11:
				step = {seq_ctrl_pkg::st_s16, seq_ctrl_pkg::act_latch};
			seq_ctrl_pkg::st_s12:
				step = {seq_ctrl_pkg::st_s17, seq_ctrl_pkg::act_latch};
			seq_ctrl_pkg::st_s13:
				step = {seq_ctrl_pkg::st_s18, seq_ctrl_pkg::act_latch};
			seq_ctrl_pkg::st_s14:
			begin
				// With x12 set the branch follows x2, x1, x18 and x16 directly
				if (x[11] && x[1] && !x[15])
					step = {seq_ctrl_pkg::st_s19, seq_ctrl_pkg::act_mem_access};
				else if (x[11] && x[0])
					step = {seq_ctrl_pkg::st_s20, seq_ctrl_pkg::act_call};
				else if (x[11] && x[17])
					step = x[15] ? {seq_ctrl_pkg::st_s21, seq_ctrl_pkg::act_load}
						: {seq_ctrl_pkg::st_s22, seq_ctrl_pkg::act_wide_op};
				else if (x[11])
					step = {seq_ctrl_pkg::st_s23, seq_ctrl_pkg::act_load_ready};
				else if (x[12] && !ready_ok)
					step = exit_step;
				else if (x[12] && x[1])
					step = {seq_ctrl_pkg::st_s5, seq_ctrl_pkg::act_return};
				else if (x[1])
					step = x[13] ? {seq_ctrl_pkg::st_s24, seq_ctrl_pkg::act_block}
						: {seq_ctrl_pkg::st_s21, seq_ctrl_pkg::act_load};
				else if (x[0])
					step = {seq_ctrl_pkg::st_s20, seq_ctrl_pkg::act_call};
				else if (x[17])
					step = {seq_ctrl_pkg::st_s22, seq_ctrl_pkg::act_wide_op};
				else
					step = {seq_ctrl_pkg::st_s23, seq_ctrl_pkg::act_load_ready};
			end
			seq_ctrl_pkg::st_s15:
				step = {seq_ctrl_pkg::st_s25, seq_ctrl_pkg::act_latch};
			seq_ctrl_pkg::st_s16:
				step = {seq_ctrl_pkg::st_s26, seq_ctrl_pkg::act_strobe};
			seq_ctrl_pkg::st_s17:
				step = {seq_ctrl_pkg::st_s27, seq_ctrl_pkg::act_strobe};
			seq_ctrl_pkg::st_s18:
				step = {seq_ctrl_pkg::st_s5, seq_ctrl_pkg::act_finish};
			seq_ctrl_pkg::st_s19:
				step = {seq_ctrl_pkg::st_s21, seq_ctrl_pkg::act_load};
			seq_ctrl_pkg::st_s20:
				step = {seq_ctrl_pkg::st_s28, seq_ctrl_pkg::act_mark};
			seq_ctrl_pkg::st_s21:
				step = (x[11] && !x[15]) ? {seq_ctrl_pkg::st_s13, seq_ctrl_pkg::act_commit}
					: {seq_ctrl_pkg::st_s11, seq_ctrl_pkg::act_step};
			seq_ctrl_pkg::st_s22:
			begin
				if (x[11])
					step = {seq_ctrl_pkg::st_s21, seq_ctrl_pkg::act_load};
				else if (x[12])
					step = {seq_ctrl_pkg::st_s5, seq_ctrl_pkg::act_restart};
				else
					step = {seq_ctrl_pkg::st_s29, seq_ctrl_pkg::act_probe};
			end
			seq_ctrl_pkg::st_s23:
				step = {seq_ctrl_pkg::st_s30, seq_ctrl_pkg::act_step};
			seq_ctrl_pkg::st_s24:
				step = {seq_ctrl_pkg::st_s7, seq_ctrl_pkg::act_mem_read};
			seq_ctrl_pkg::st_s25:
				step = {seq_ctrl_pkg::st_s31, seq_ctrl_pkg::act_strobe};
			seq_ctrl_pkg::st_s26:
				step = x[11] ? {seq_ctrl_pkg::st_s5,
					x[12] ? seq_ctrl_pkg::act_pair : seq_ctrl_pkg::act_resume}
					: {seq_ctrl_pkg::st_s24, seq_ctrl_pkg::act_block};
			seq_ctrl_pkg::st_s27:
				step = (x[14] || x[13]) ? {seq_ctrl_pkg::st_s24, seq_ctrl_pkg::act_block}
					: {seq_ctrl_pkg::st_s7, seq_ctrl_pkg::act_load_ready};
			seq_ctrl_pkg::st_s28:
			begin
				if (x[17] && x[11] && x[15])
					step = {seq_ctrl_pkg::st_s21, seq_ctrl_pkg::act_load};
				else if (x[17])
					step = {seq_ctrl_pkg::st_s22, seq_ctrl_pkg::act_wide_op};
				else
					step = {seq_ctrl_pkg::st_s23, seq_ctrl_pkg::act_load_ready};
			end
			seq_ctrl_pkg::st_s29:
				step = x[13] ? {seq_ctrl_pkg::st_s24, seq_ctrl_pkg::act_block}
					: {seq_ctrl_pkg::st_s21, seq_ctrl_pkg::act_load};
			seq_ctrl_pkg::st_s30:
				step = {seq_ctrl_pkg::st_s32, seq_ctrl_pkg::act_latch};
			seq_ctrl_pkg::st_s31:
			begin
				if (x[11] && !x[0] && !x[15])
					step = {seq_ctrl_pkg::st_s21, seq_ctrl_pkg::act_load};
				else if (!x[11] && x[12])
					step = {seq_ctrl_pkg::st_s5, seq_ctrl_pkg::act_restart};
				else
					step = {seq_ctrl_pkg::st_s33, seq_ctrl_pkg::act_probe};
			end
			seq_ctrl_pkg::st_s32:
				step = {seq_ctrl_pkg::st_s34, seq_ctrl_pkg::act_strobe};
			seq_ctrl_pkg::st_s33:
			begin
				if (x[11] ? !x[15] : x[0])
					step = {seq_ctrl_pkg::st_s22, seq_ctrl_pkg::act_wide_op};
				else if (!x[11] && x[13])
					step = {seq_ctrl_pkg::st_s24, seq_ctrl_pkg::act_block};
				else
					step = {seq_ctrl_pkg::st_s21, seq_ctrl_pkg::act_load};
			end
			seq_ctrl_pkg::st_s34:
				step = {seq_ctrl_pkg::st_s35, seq_ctrl_pkg::act_flush};
			seq_ctrl_pkg::st_s35:
				step = {seq_ctrl_pkg::st_s36, seq_ctrl_pkg::act_mark};
			seq_ctrl_pkg::st_s36:
				step = (x[11] && x[15]) ? {seq_ctrl_pkg::st_s21, seq_ctrl_pkg::act_load}
					: {seq_ctrl_pkg::st_s22, seq_ctrl_pkg::act_wide_op};
			default:
				step = {seq_ctrl_pkg::st_idle, seq_ctrl_pkg::act_none};
		endcase
		state_d = seq_ctrl_pkg::ctrl_state_t'(step[action_bits +: state_bits]);
		action = seq_ctrl_pkg::action_t'(step[action_bits-1:0]);
	end

endmodule

`default_nettype wire

// ==== cond_eval.sv ====
`timescale 1ns/10ps
`default_nettype none

module cond_eval (
	input wire seq_ctrl_pkg::cond_vec_t x,
	output logic exit_ok,
	output logic ready_ok
);

	// Exit is granted by x17 together with either x10 or x11
	assign exit_ok = x[16] & (x[9] | x[10]);

	// x15 and x16 pick which of x7, x8 or x9 signals ready
	always_comb
	begin
		case ({x[14], x[15]})
			2'b10:
				ready_ok = x[8];
			2'b01:
				ready_ok = x[7];
			2'b00:
				ready_ok = x[6];
			default:
				ready_ok = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

// ==== seq_ctrl_pkg.sv ====
`default_nettype none

package seq_ctrl_pkg;

	localparam int cond_width = 20;
	localparam int ctrl_width = 39;

	// Bit k-1 carries condition xk or control output yk
	typedef logic [cond_width-1:0] cond_vec_t;
	typedef logic [ctrl_width-1:0] ctrl_word_t;

	// States keep the s1 to s36 numbering, s1 being the idle state
	typedef enum logic [5:0] {
		st_idle, st_s2, st_s3, st_s4, st_s5, st_s6,
		st_s7, st_s8, st_s9, st_s10, st_s11, st_s12,
		st_s13, st_s14, st_s15, st_s16, st_s17, st_s18,
		st_s19, st_s20, st_s21, st_s22, st_s23, st_s24,
		st_s25, st_s26, st_s27, st_s28, st_s29, st_s30,
		st_s31, st_s32, st_s33, st_s34, st_s35, st_s36
	} ctrl_state_t;

	// One code per distinct set of raised control outputs
	typedef enum logic [5:0] {
		act_none,
		act_idle_full, act_idle_hold, act_idle_alt, act_idle_wait,
		act_start_short, act_start_long, act_short_done,
		act_fetch, act_dir_pos, act_dir_neg, act_load,
		act_mem_write, act_exit, act_branch, act_load_ready,
		act_step, act_commit, act_latch, act_call,
		act_mem_access, act_wide_op, act_return, act_block,
		act_strobe, act_finish, act_mark, act_restart,
		act_probe, act_mem_read, act_pair, act_resume,
		act_flush
	} action_t;

endpackage

`default_nettype wire
